/* pd_config.svh */
// PID codes, device address and meta byte codes
// Packet and payload byte counts for the decoder

`ifndef PD_CONFIG_SVH
`define PD_CONFIG_SVH

// Token and data PIDs, complement nibble in the upper half
`define PD_PID_OUT   8'hE1
`define PD_PID_IN    8'h69
`define PD_PID_DATA0 8'hC3
`define PD_PID_DATA1 8'h4B

// Address sits in bits 7 to 1 of the token address byte
`define PD_DEV_ADDR 7'h61

// Meta byte after a DATA PID
`define PD_META_INTR 8'h00
`define PD_META_HASH 8'hFF

// Header payload split over DATA0 and DATA1
`define PD_CHUNK0_BYTES 64
`define PD_CHUNK1_BYTES 16

// Whole packet lengths, PID included
`define PD_TOKEN_BYTES 3
`define PD_INTR_BYTES  4
`define PD_CRC_BYTES   2

`endif

/* pd_pkg.sv */
// Shared types for the packet decoder
// PID, state and block select enums; byte and buffer load structs

`default_nettype none

package pd_pkg;

	// Classified PID of the first byte of a packet
	typedef enum logic [2:0]
	{
		PID_OUT,
		PID_IN,
		PID_DATA0,
		PID_DATA1,
		PID_BAD
	} pd_pid_t;

	typedef enum logic [3:0]
	{
		IDLE,
		TOKEN_ADDR,
		TOKEN_CRC,
		DATA_META,
		DATA_PAYLOAD,
		DATA_CRC,
		INTR_TAIL,
		WAIT_EOP,
		DROP
	} pd_state_t;

	// Which 512-bit block goes to the hasher
	typedef enum logic
	{
		SEL_BLOCK0,
		SEL_BLOCK1
	} pd_hash_sel_t;

	// Received byte with its one-cycle strobe
	typedef struct packed
	{
		logic [7:0] data;
		logic       strobe;
	} pd_rx_byte_t;

	// Controller to chunk buffer; chunk 0 is DATA0, chunk 1 is DATA1
	typedef struct packed
	{
		logic       write;
		logic       chunk;
		logic [5:0] index;
		logic [7:0] data;
		logic       clear;
	} pd_load_t;

endpackage

`default_nettype wire

/* pd_pid_decoder.sv */
// PID decoder
// Complement nibble check and classification of the four known PIDs

`default_nettype none

`include "pd_config.svh"

module pd_pid_decoder
(
	input  pd_pkg::pd_rx_byte_t rx_byte,
	output pd_pkg::pd_pid_t     pid
);

	logic nibble_ok;

	// Upper nibble must be the inverse of the lower one
	assign nibble_ok = (rx_byte.data[7:4] == ~rx_byte.data[3:0]);

	always_comb
	begin
		pid = pd_pkg::PID_BAD;
		if (nibble_ok)
		begin
			case (rx_byte.data)
				`PD_PID_OUT:
					pid = pd_pkg::PID_OUT;
				`PD_PID_IN:
					pid = pd_pkg::PID_IN;
				`PD_PID_DATA0:
					pid = pd_pkg::PID_DATA0;
				`PD_PID_DATA1:
					pid = pd_pkg::PID_DATA1;
				// Valid complement but a code this device does not handle
				default:
					pid = pd_pkg::PID_BAD;
			endcase
		end
	end

endmodule

`default_nettype wire

/* pd_controller.sv */
// Packet FSM with byte counting and token address match
// DATA0/DATA1 ordering, length check, outcome pulses and buffer writes

`default_nettype none

`include "pd_config.svh"

module pd_controller
(
	input  logic                tb_clk,
	input  logic                reset,
	input  pd_pkg::pd_rx_byte_t rx_byte,
	input  pd_pkg::pd_pid_t     pid,
	input  logic                end_pulse,
	input  logic                hash_done,
	input  logic                valid_hash,
	output pd_pkg::pd_load_t    load,
	output logic                p_error,
	output logic                transmit_ack,
	output logic                r_enable,
	output logic                new_block,
	output logic                host_ready
);

	pd_pkg::pd_state_t state;
	pd_pkg::pd_pid_t   cur_pid;
	logic [6:0]        cnt;
	logic [6:0]        exp_len;
	logic [5:0]        pay_idx;
	logic              out_armed;
	logic              chunk0_valid;
	logic              pending;
	logic              drop_err;
	logic              intr_pkt;
	logic              is_data1;
	logic              pay_last;
	logic              end_ok;

	assign is_data1 = (cur_pid == pd_pkg::PID_DATA1);
	assign pay_last = is_data1 ? (pay_idx == 6'(`PD_CHUNK1_BYTES - 1))
		: (pay_idx == 6'(`PD_CHUNK0_BYTES - 1));

	// Packet ended in a live state with the length it promised
	assign end_ok = end_pulse && (state != pd_pkg::IDLE) && (state != pd_pkg::DROP)
		&& (cnt == exp_len);

	always_comb
	begin
		load.write = rx_byte.strobe && !end_pulse && (state == pd_pkg::DATA_PAYLOAD);
		load.chunk = is_data1;
		load.index = pay_idx;
		load.data  = rx_byte.data;
		load.clear = end_ok && intr_pkt;
	end

	always_ff @(posedge tb_clk)
	begin
		if (reset)
		begin
			state        <= pd_pkg::IDLE;
			cur_pid      <= pd_pkg::PID_BAD;
			cnt          <= '0;
			exp_len      <= '0;
			pay_idx      <= '0;
			out_armed    <= 1'b0;
			chunk0_valid <= 1'b0;
			pending      <= 1'b0;
			drop_err     <= 1'b0;
			intr_pkt     <= 1'b0;
			host_ready   <= 1'b0;
			p_error      <= 1'b0;
			transmit_ack <= 1'b0;
			r_enable     <= 1'b0;
			new_block    <= 1'b0;
		end
		else
		begin
			p_error      <= 1'b0;
			transmit_ack <= 1'b0;
			r_enable     <= 1'b0;
			new_block    <= 1'b0;
			if (end_pulse)
			begin
				state     <= pd_pkg::IDLE;
				cnt       <= '0;
				// An OUT only arms the packet right after it
				out_armed <= 1'b0;
				if (state == pd_pkg::DROP)
					p_error <= drop_err;
				else if ((state != pd_pkg::IDLE) && !end_ok)
					p_error <= 1'b1;
				else if (end_ok)
				begin
					case (cur_pid)
						pd_pkg::PID_OUT:
							out_armed <= 1'b1;
						pd_pkg::PID_IN:
						begin
							if (pending)
							begin
								r_enable <= 1'b1;
								pending  <= 1'b0;
							end
						end
						default:
						begin
							transmit_ack <= 1'b1;
							if (intr_pkt)
							begin
								// Job aborted
								chunk0_valid <= 1'b0;
								host_ready   <= 1'b0;
							end
							else if (is_data1)
							begin
								host_ready <= chunk0_valid;
								new_block  <= chunk0_valid;
							end
							else
								chunk0_valid <= 1'b1;
						end
					endcase
				end
			end
			else if (rx_byte.strobe)
			begin
				if (cnt != 7'h7f)
					cnt <= cnt + 7'd1;
				case (state)
					pd_pkg::IDLE:
					begin
						cur_pid  <= pid;
						drop_err <= 1'b0;
						intr_pkt <= 1'b0;
						exp_len  <= 7'(`PD_TOKEN_BYTES);
						case (pid)
							pd_pkg::PID_OUT, pd_pkg::PID_IN:
								state <= pd_pkg::TOKEN_ADDR;
							pd_pkg::PID_DATA0, pd_pkg::PID_DATA1:
							begin
								state    <= out_armed ? pd_pkg::DATA_META : pd_pkg::DROP;
								drop_err <= !out_armed;
							end
							default:
							begin
								state    <= pd_pkg::DROP;
								drop_err <= 1'b1;
							end
						endcase
					end
					// Foreign address drops silently
					pd_pkg::TOKEN_ADDR:
						state <= (rx_byte.data[7:1] == `PD_DEV_ADDR) ? pd_pkg::TOKEN_CRC
							: pd_pkg::DROP;
					pd_pkg::TOKEN_CRC, pd_pkg::DATA_CRC, pd_pkg::INTR_TAIL:
					begin
						if (cnt + 7'd1 == exp_len)
							state <= pd_pkg::WAIT_EOP;
					end
					pd_pkg::DATA_META:
					begin
						if (rx_byte.data == `PD_META_INTR)
						begin
							intr_pkt <= 1'b1;
							exp_len  <= 7'(`PD_INTR_BYTES);
							state    <= pd_pkg::INTR_TAIL;
						end
						else if (rx_byte.data != `PD_META_HASH)
						begin
							state    <= pd_pkg::DROP;
							drop_err <= 1'b1;
						end
						else if (is_data1 && !chunk0_valid)
						begin
							state    <= pd_pkg::DROP;
							drop_err <= 1'b1;
						end
						else
						begin
							state      <= pd_pkg::DATA_PAYLOAD;
							pay_idx    <= '0;
							host_ready <= 1'b0;
							// New DATA0 overwrites chunk 0, so it is stale until the end
							if (!is_data1)
								chunk0_valid <= 1'b0;
							exp_len <= is_data1
								? 7'(`PD_CHUNK1_BYTES + `PD_CRC_BYTES + 2)
								: 7'(`PD_CHUNK0_BYTES + `PD_CRC_BYTES + 2);
						end
					end
					pd_pkg::DATA_PAYLOAD:
					begin
						pay_idx <= pay_idx + 6'd1;
						if (pay_last)
							state <= pd_pkg::DATA_CRC;
					end
					// WAIT_EOP and DROP only count
					default:
						state <= state;
				endcase
			end
			// Set after the IN check so a same-cycle result is kept
			if (hash_done && valid_hash)
				pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* pd_chunk_buffer.sv */
// Header byte store for the 80-byte block header
// Nonce increment and the two padded 512-bit hash blocks

`default_nettype none

`include "pd_config.svh"

module pd_chunk_buffer
(
	input  logic                 tb_clk,
	input  logic                 reset,
	input  pd_pkg::pd_load_t     load,
	input  logic                 increment,
	input  pd_pkg::pd_hash_sel_t hash_select,
	output logic [511:0]         data_to_hash,
	output logic [31:0]          bits_word
);

	logic [7:0]   head [`PD_CHUNK0_BYTES];
	logic [7:0]   tail [`PD_CHUNK1_BYTES];
	logic [31:0]  nonce;
	logic [31:0]  nonce_inc;
	logic [511:0] block0;
	logic [511:0] block1;

	// Nonce is tail bytes 12 to 15, little endian
	assign nonce     = {tail[15], tail[14], tail[13], tail[12]};
	assign nonce_inc = nonce + 32'd1;
	assign bits_word = {tail[11], tail[10], tail[9], tail[8]};

	always_ff @(posedge tb_clk)
	begin
		if (reset || load.clear)
		begin
			for (int i = 0; i < `PD_CHUNK0_BYTES; i++)
				head[i] <= '0;
			for (int i = 0; i < `PD_CHUNK1_BYTES; i++)
				tail[i] <= '0;
		end
		else
		begin
			if (increment)
			begin
				tail[12] <= nonce_inc[7:0];
				tail[13] <= nonce_inc[15:8];
				tail[14] <= nonce_inc[23:16];
				tail[15] <= nonce_inc[31:24];
			end
			// A byte write wins over the increment
			if (load.write)
			begin
				if (load.chunk)
					tail[load.index[3:0]] <= load.data;
				else
					head[load.index] <= load.data;
			end
		end
	end

	always_comb
	begin
		block0 = '0;
		block1 = '0;
		for (int i = 0; i < `PD_CHUNK0_BYTES; i++)
			block0[511 - 8 * i -: 8] = head[i];
		for (int i = 0; i < `PD_CHUNK1_BYTES; i++)
			block1[511 - 8 * i -: 8] = tail[i];
		// Pad byte after the 80-byte message, then its length in bits
		block1[383:376] = 8'h80;
		block1[63:0]    = 64'd640;
	end

	assign data_to_hash = (hash_select == pd_pkg::SEL_BLOCK1) ? block1 : block0;

endmodule

`default_nettype wire

/* pd_target_expander.sv */
// Compact bits to 256-bit difficulty target
// Saturates to all ones when the target does not fit

`default_nettype none

module pd_target_expander
(
	input  logic [31:0]  bits_word,
	output logic [255:0] difficulty
);

	logic [7:0]   expo;
	logic [23:0]  mant;
	logic [7:0]   up;
	logic [7:0]   down;
	logic [287:0] wide;

	assign expo = bits_word[31:24];
	assign mant = bits_word[23:0];
	assign up   = expo - 8'd3;
	assign down = 8'd3 - expo;

	// Room above bit 255 to see what a left shift pushes out
	assign wide = {264'd0, mant} << {up[5:0], 3'b000};

	always_comb
	begin
		if (expo < 8'd3)
			difficulty = {232'd0, mant >> {down[1:0], 3'b000}};
		else if (expo > 8'd34)
			difficulty = (mant != '0) ? '1 : '0;
		else if (|wide[287:256])
			difficulty = '1;
		else
			difficulty = wide[255:0];
	end

endmodule

`default_nettype wire

/* pd_top.sv */
// Packet decoder top level
// Input edge detectors, PID decoder, controller and header datapath

`default_nettype none

module pd_top
(
	input  logic                 tb_clk,
	input  logic                 reset,
	input  logic                 write_enable,
	input  logic [7:0]           rx_data,
	input  logic                 eop,
	input  pd_pkg::pd_hash_sel_t hash_select,
	input  logic                 increment,
	input  logic                 valid_hash,
	input  logic                 hash_done,
	output logic [511:0]         data_to_hash,
	output logic                 p_error,
	output logic                 host_ready,
	output logic [255:0]         difficulty,
	output logic                 new_block,
	output logic                 r_enable,
	output logic                 transmit_ack
);

	logic                we_q;
	logic                eop_q;
	logic                rx_strobe;
	logic [7:0]          rx_data_q;
	logic                end_pulse;
	logic [31:0]         bits_word;
	pd_pkg::pd_rx_byte_t rx_byte;
	pd_pkg::pd_pid_t     pid;
	pd_pkg::pd_load_t    load;

	// Rising edges only, so a held write_enable gives one byte
	always_ff @(posedge tb_clk)
	begin
		if (reset)
		begin
			we_q      <= 1'b0;
			eop_q     <= 1'b0;
			rx_strobe <= 1'b0;
			end_pulse <= 1'b0;
		end
		else
		begin
			we_q      <= write_enable;
			eop_q     <= eop;
			rx_strobe <= write_enable && !we_q;
			end_pulse <= eop && !eop_q;
		end
	end

	always_ff @(posedge tb_clk)
	begin
		if (write_enable && !we_q)
			rx_data_q <= rx_data;
	end

	assign rx_byte.data   = rx_data_q;
	assign rx_byte.strobe = rx_strobe;

	pd_pid_decoder u_pid_decoder
	(
		.rx_byte (rx_byte),
		.pid     (pid)
	);

	pd_controller u_controller
	(
		.tb_clk       (tb_clk),
		.reset        (reset),
		.rx_byte      (rx_byte),
		.pid          (pid),
		.end_pulse    (end_pulse),
		.hash_done    (hash_done),
		.valid_hash   (valid_hash),
		.load         (load),
		.p_error      (p_error),
		.transmit_ack (transmit_ack),
		.r_enable     (r_enable),
		.new_block    (new_block),
		.host_ready   (host_ready)
	);

	pd_chunk_buffer u_chunk_buffer
	(
		.tb_clk       (tb_clk),
		.reset        (reset),
		.load         (load),
		.increment    (increment),
		.hash_select  (hash_select),
		.data_to_hash (data_to_hash),
		.bits_word    (bits_word)
	);

	pd_target_expander u_target_expander
	(
		.bits_word  (bits_word),
		.difficulty (difficulty)
	);

endmodule

`default_nettype wire

/* pd_checker.sv */
// Concurrent assertions on the decoder outputs
// Pulse width, outcome exclusivity and host_ready after reset

`default_nettype none

module pd_checker
(
	input logic tb_clk,
	input logic reset,
	input logic p_error,
	input logic transmit_ack,
	input logic r_enable,
	input logic new_block,
	input logic host_ready
);

	timeunit 1ns;
	timeprecision 100ps;

	// Count of failed assertions
	int fail_count = 0;

	// Every outcome pulse lasts a single cycle
	p_error_width: assert property (@(posedge tb_clk) disable iff (reset)
		p_error |=> !p_error)
	else
	begin
		$error("p_error stayed high for more than one cycle");
		fail_count++;
	end
	ack_width: assert property (@(posedge tb_clk) disable iff (reset)
		transmit_ack |=> !transmit_ack)
	else
	begin
		$error("transmit_ack stayed high for more than one cycle");
		fail_count++;
	end
	r_enable_width: assert property (@(posedge tb_clk) disable iff (reset)
		r_enable |=> !r_enable)
	else
	begin
		$error("r_enable stayed high for more than one cycle");
		fail_count++;
	end
	new_block_width: assert property (@(posedge tb_clk) disable iff (reset)
		new_block |=> !new_block)
	else
	begin
		$error("new_block stayed high for more than one cycle");
		fail_count++;
	end

	// One outcome per packet
	outcome_onehot: assert property (@(posedge tb_clk) disable iff (reset)
		$onehot0({p_error, transmit_ack, r_enable}))
	else
	begin
		$error("more than one outcome pulse high in the same cycle");
		fail_count++;
	end

	// new_block only comes with the ack of the DATA1 packet
	new_block_with_ack: assert property (@(posedge tb_clk) disable iff (reset)
		new_block |-> transmit_ack)
	else
	begin
		$error("new_block without transmit_ack");
		fail_count++;
	end

	host_ready_reset: assert property (@(posedge tb_clk) reset |=> !host_ready)
	else
	begin
		$error("host_ready high in the cycle after reset");
		fail_count++;
	end

endmodule

bind pd_top pd_checker u_checker
(
	.tb_clk       (tb_clk),
	.reset        (reset),
	.p_error      (p_error),
	.transmit_ack (transmit_ack),
	.r_enable     (r_enable),
	.new_block    (new_block),
	.host_ready   (host_ready)
);

`default_nettype wire

/* tb_pd_top.sv */
// Testbench for the packet decoder top level
// Pattern reader, byte driver, header and target models, watchdog and report

`default_nettype none

`include "pd_config.svh"

module tb_pd_top;

	timeunit 1ns;
	timeprecision 100ps;

	logic                 tb_clk;
	logic                 reset;
	logic                 write_enable;
	logic [7:0]           rx_data;
	logic                 eop;
	pd_pkg::pd_hash_sel_t hash_select;
	logic                 increment;
	logic                 valid_hash;
	logic                 hash_done;
	logic [511:0]         data_to_hash;
	logic                 p_error;
	logic                 host_ready;
	logic [255:0]         difficulty;
	logic                 new_block;
	logic                 r_enable;
	logic                 transmit_ack;

	// Expected 80-byte header image
	logic [7:0]  img [80];
	logic [31:0] lcg_state;
	logic        line_bad;
	int          errors = 0;
	int          tests = 0;
	int          failed = 0;
	int          limit_cycles = 0;
	int          cnt_pe = 0;
	int          cnt_ta = 0;
	int          cnt_re = 0;
	int          cnt_nb = 0;

	pd_top u_pd_top
	(
		.tb_clk       (tb_clk),
		.reset        (reset),
		.write_enable (write_enable),
		.rx_data      (rx_data),
		.eop          (eop),
		.hash_select  (hash_select),
		.increment    (increment),
		.valid_hash   (valid_hash),
		.hash_done    (hash_done),
		.data_to_hash (data_to_hash),
		.p_error      (p_error),
		.host_ready   (host_ready),
		.difficulty   (difficulty),
		.new_block    (new_block),
		.r_enable     (r_enable),
		.transmit_ack (transmit_ack)
	);

	initial
		tb_clk = 1'b0;
	always #4 tb_clk = ~tb_clk;

	// Pulse counters, sampled away from the active edge
	always @(negedge tb_clk)
	begin
		cnt_pe = cnt_pe + p_error;
		cnt_ta = cnt_ta + transmit_ack;
		cnt_re = cnt_re + r_enable;
		cnt_nb = cnt_nb + new_block;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] fill_byte(input int pos);
		return 8'(pos * 37 + 11);
	endfunction

	function automatic logic [511:0] model_block(input logic sel);
		logic [511:0] blk;
		logic [127:0] tail_bits;
		blk = '0;
		tail_bits = '0;
		if (!sel)
		begin
			for (int i = 0; i < 64; i++)
				blk = {blk[503:0], img[i]};
		end
		else
		begin
			for (int i = 0; i < 16; i++)
				tail_bits = {tail_bits[119:0], img[64 + i]};
			// Message, pad byte, zeros, 64-bit length of 640 bits
			blk = {tail_bits, 8'h80, 312'd0, 64'd640};
		end
		return blk;
	endfunction

	// Mantissa times 256 to the power of exponent minus 3
	function automatic logic [255:0] model_target(input logic [31:0] bits);
		logic [511:0] acc;
		logic         over;
		int           e;
		e = bits[31:24];
		acc = {488'd0, bits[23:0]};
		over = 1'b0;
		if (e < 3)
			return 256'(acc >> (8 * (3 - e)));
		for (int k = 0; k < e - 3; k++)
		begin
			acc = acc << 8;
			if (acc[511:256] != '0)
				over = 1'b1;
		end
		return over ? '1 : acc[255:0];
	endfunction

	task automatic check_value(input string name, input logic [511:0] exp_v,
		input logic [511:0] got_v);
		assert (got_v === exp_v)
		else
		begin
			$display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp_v, got_v);
			errors++;
			line_bad = 1'b1;
		end
	endtask

	// Two cycles high, six low
	task automatic send_byte(input logic [7:0] value);
		@(negedge tb_clk);
		rx_data = value;
		write_enable = 1'b1;
		repeat (2) @(negedge tb_clk);
		write_enable = 1'b0;
		repeat (5) @(negedge tb_clk);
	endtask

	// eop for two cycles, then room for the outcome pulse
	task automatic end_packet();
		@(negedge tb_clk);
		eop = 1'b1;
		repeat (2) @(negedge tb_clk);
		eop = 1'b0;
		repeat (6) @(negedge tb_clk);
	endtask

	task automatic send_crc_and_end();
		send_byte(8'hA5);
		send_byte(8'h5A);
		end_packet();
	endtask

	task automatic send_data(input logic [7:0] pid_byte, input logic [7:0] meta, input int n,
		input logic accepted);
		int base;
		base = (pid_byte == `PD_PID_DATA1) ? `PD_CHUNK0_BYTES : 0;
		send_byte(pid_byte);
		send_byte(meta);
		for (int i = 0; i < n; i++)
			send_byte(fill_byte(base + i));
		send_crc_and_end();
		if (accepted && meta == `PD_META_HASH)
		begin
			for (int i = 0; i < n; i++)
				img[base + i] = fill_byte(base + i);
		end
		else if (accepted && meta == `PD_META_INTR)
		begin
			// Interrupt wipes the whole header
			for (int i = 0; i < 80; i++)
				img[i] = 8'h00;
		end
	endtask

	// DATA1 with random tail bytes around the given bits and nonce
	task automatic send_tail(input logic [31:0] bits, input logic [31:0] nonce,
		input logic accepted);
		logic [7:0] tail [16];
		for (int j = 0; j < 16; j++)
		begin
			if (j >= 8 && j < 12)
				tail[j] = bits[8 * (j - 8) +: 8];
			else if (j >= 12)
				tail[j] = nonce[8 * (j - 12) +: 8];
			else
			begin
				lcg_state = lcg_next(lcg_state);
				tail[j] = lcg_state[23:16];
			end
		end
		send_byte(`PD_PID_DATA1);
		send_byte(`PD_META_HASH);
		for (int j = 0; j < 16; j++)
			send_byte(tail[j]);
		send_crc_and_end();
		if (accepted)
		begin
			for (int j = 0; j < 16; j++)
				img[64 + j] = tail[j];
		end
	endtask

	task automatic pulse_increments(input int n);
		logic [31:0] nonce;
		repeat (n)
		begin
			@(negedge tb_clk);
			increment = 1'b1;
			@(negedge tb_clk);
			increment = 1'b0;
		end
		repeat (2) @(negedge tb_clk);
		// Nonce is little endian in the last four header bytes
		nonce = {img[79], img[78], img[77], img[76]} + 32'(n);
		img[76] = nonce[7:0];
		img[77] = nonce[15:8];
		img[78] = nonce[23:16];
		img[79] = nonce[31:24];
	endtask

	task automatic post_result();
		@(negedge tb_clk);
		hash_done = 1'b1;
		valid_hash = 1'b1;
		@(negedge tb_clk);
		hash_done = 1'b0;
		valid_hash = 1'b0;
		repeat (2) @(negedge tb_clk);
	endtask

	task automatic check_header(input logic hr);
		check_value("host_ready", hr, host_ready);
		@(negedge tb_clk);
		hash_select = pd_pkg::SEL_BLOCK0;
		@(negedge tb_clk);
		check_value("data_to_hash block 0", model_block(1'b0), data_to_hash);
		hash_select = pd_pkg::SEL_BLOCK1;
		@(negedge tb_clk);
		check_value("data_to_hash block 1", model_block(1'b1), data_to_hash);
		check_value("difficulty", model_target({img[75], img[74], img[73], img[72]}),
			difficulty);
	endtask

	// Next command line, skipping lines that start with #
	task automatic read_line(input int fd, output logic ok, output logic [7:0] cmd,
		output logic [31:0] a, output logic [31:0] b, output logic [31:0] c,
		output logic pe, output logic ta, output logic re, output logic nb);
		logic [1023:0] junk;
		logic          done;
		int            code;
		ok = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1)
				done = 1'b1;
			else if (cmd == "#")
				code = $fgets(junk, fd);
			else
			begin
				code = $fscanf(fd, "%h %h %h %b %b %b %b", a, b, c, pe, ta, re, nb);
				ok = (code == 7);
				done = 1'b1;
			end
		end
	endtask

	initial
	begin
		int          fd;
		int          n_bytes;
		int          n_lines;
		int          base_pe;
		int          base_ta;
		int          base_re;
		int          base_nb;
		logic        ok;
		logic        at_end;
		logic [7:0]  cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic        pe;
		logic        ta;
		logic        re;
		logic        nb;
		reset = 1'b1;
		write_enable = 1'b0;
		rx_data = 8'h00;
		eop = 1'b0;
		hash_select = pd_pkg::SEL_BLOCK0;
		increment = 1'b0;
		valid_hash = 1'b0;
		hash_done = 1'b0;
		lcg_state = 32'hb887;
		n_bytes = 0;
		n_lines = 0;
		for (int i = 0; i < 80; i++)
			img[i] = 8'h00;
		fd = $fopen("pd_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file pd_patterns.txt");
			errors++;
		end
		else
		begin
			// First pass sizes the watchdog
			at_end = 1'b0;
			while (!at_end)
			begin
				read_line(fd, ok, cmd, a, b, c, pe, ta, re, nb);
				if (!ok)
					at_end = 1'b1;
				else
				begin
					n_lines++;
					if (cmd == "T")
						n_bytes += `PD_TOKEN_BYTES;
					else if (cmd == "D")
						n_bytes += 4 + c;
					else if (cmd == "R")
						n_bytes += 4 + `PD_CHUNK1_BYTES;
				end
			end
			$fclose(fd);
			limit_cycles = n_bytes * 8 + n_lines * 32 + 100;
			fd = $fopen("pd_patterns.txt", "r");
			repeat (3) @(negedge tb_clk);
			reset = 1'b0;
			repeat (2) @(negedge tb_clk);
			at_end = 1'b0;
			while (!at_end)
			begin
				read_line(fd, ok, cmd, a, b, c, pe, ta, re, nb);
				if (!ok)
					at_end = 1'b1;
				else
				begin
					tests++;
					line_bad = 1'b0;
					base_pe = cnt_pe;
					base_ta = cnt_ta;
					base_re = cnt_re;
					base_nb = cnt_nb;
					case (cmd)
						"T":
						begin
							send_byte(a[7:0]);
							send_byte(b[7:0]);
							send_byte(c[7:0]);
							end_packet();
						end
						"D":
							send_data(a[7:0], b[7:0], c, ta);
						"R":
							send_tail(a, b, ta);
						"I":
							pulse_increments(a);
						"V":
							post_result();
						"C":
							check_header(a[0]);
						default:
						begin
							$display("Unknown command %c in the pattern file", cmd);
							errors++;
							line_bad = 1'b1;
						end
					endcase
					check_value("p_error pulses", pe, cnt_pe - base_pe);
					check_value("transmit_ack pulses", ta, cnt_ta - base_ta);
					check_value("r_enable pulses", re, cnt_re - base_re);
					check_value("new_block pulses", nb, cnt_nb - base_nb);
					if (line_bad)
						failed++;
					$display("Test %0d %c %0h %0h: %s", tests, cmd, a, b,
						line_bad ? "FAILED" : "ok");
				end
			end
			$fclose(fd);
		end
		if (u_pd_top.u_checker.fail_count != 0)
		begin
			$display("Checker assertions failed %0d times", u_pd_top.u_checker.fail_count);
			errors += u_pd_top.u_checker.fail_count;
		end
		$display("Tests %0d, failed %0d, checks in error %0d", tests, failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog sized from the pattern length
	initial
	begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge tb_clk);
		$display("Timeout: the pattern run did not finish within %0d cycles", limit_cycles);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* pd_patterns.txt */
# cmd a b c p_error transmit_ack r_enable new_block (a b c hex, flags binary)
# T token bytes a b c; D pid a meta b, c payload bytes; R DATA1 bits a nonce b; I a increments; V result; C host_ready a
T E2 C2 00 1 0 0 0
D C3 FF 40 1 0 0 0
T E1 C2 00 0 0 0 0
D 4B FF 10 1 0 0 0
T E1 C2 00 0 0 0 0
D C3 FF 3F 1 0 0 0
T E1 40 00 0 0 0 0
T E1 C2 00 0 0 0 0
D C3 FF 40 0 1 0 0
T E1 C2 00 0 0 0 0
D 4B FF 10 0 1 0 1
C 1 0 0 0 0 0 0
I 3 0 0 0 0 0 0
C 1 0 0 0 0 0 0
T E1 C2 00 0 0 0 0
R 1d00ffff 0000fffe 0 0 1 0 1
I 3 0 0 0 0 0 0
C 1 0 0 0 0 0 0
T E1 C2 00 0 0 0 0
R 0300abcd ffffffff 0 0 1 0 1
I 1 0 0 0 0 0 0
C 1 0 0 0 0 0 0
T 69 C2 00 0 0 0 0
V 0 0 0 0 0 0 0
T 69 C2 00 0 0 1 0
T 69 C2 00 0 0 0 0
T E1 C2 00 0 0 0 0
D C3 00 0 0 1 0 0
C 0 0 0 0 0 0 0
T E1 C2 00 0 0 0 0
D C3 FF 40 0 1 0 0
T E1 C2 00 0 0 0 0
R 01123456 12345678 0 0 1 0 1
C 1 0 0 0 0 0 0
T E1 C2 00 0 0 0 0
R 20ffffff 00000010 0 0 1 0 1
C 1 0 0 0 0 0 0
T E1 C2 00 0 0 0 0
R 2101ffff 00000020 0 0 1 0 1
C 1 0 0 0 0 0 0
T E1 C2 00 0 0 0 0
R 24123456 00000030 0 0 1 0 1
C 1 0 0 0 0 0 0

/* sources.f */
+incdir+.
pd_pkg.sv
pd_pid_decoder.sv
pd_controller.sv
pd_chunk_buffer.sv
pd_target_expander.sv
pd_top.sv
pd_checker.sv
tb_pd_top.sv
